// ==== dv/dm_abstract_sva.sv ====
`timescale 1ns/1ps
module dm_abstract_sva (
    input logic              dm_clk,
    input logic              dm_rst_n,
    input logic              b_valid,
    input logic              b_ready,
    input dm_pkg::axi_b_t    b,
    input logic              r_valid,
    input logic              r_ready,
    input dm_pkg::axi_r_t    r,
    input dm_pkg::core_evt_t evt
);
    import dm_pkg::*;

    int fail_count = 0;

    // Response channels stall until the master takes them
    assert property (@(posedge dm_clk) disable iff (!dm_rst_n)
        b_valid && !b_ready |=> b_valid && $stable(b))
        else begin
            $error("b_valid or b dropped before b_ready");
            fail_count++;
        end

    assert property (@(posedge dm_clk) disable iff (!dm_rst_n)
        r_valid && !r_ready |=> r_valid && $stable(r))
        else begin
            $error("r_valid or r dropped before r_ready");
            fail_count++;
        end

    assert property (@(posedge dm_clk) disable iff (!dm_rst_n) r_valid |-> r.last)
        else begin
            $error("r_valid without last");
            fail_count++;
        end

    assert property (@(posedge dm_clk) disable iff (!dm_rst_n) $onehot0(evt))
        else begin
            $error("more than one core event in a cycle");
            fail_count++;
        end

endmodule

bind dm_axi_slave dm_abstract_sva i_abstract_sva (
    .dm_clk   (dm_clk),
    .dm_rst_n (dm_rst_n),
    .b_valid  (b_valid),
    .b_ready  (b_ready),
    .b        (b),
    .r_valid  (r_valid),
    .r_ready  (r_ready),
    .r        (r),
    .evt      (evt)
);

// ==== include/dm_tb_tasks.svh ====
`ifndef DM_TB_TASKS_SVH
`define DM_TB_TASKS_SVH

function automatic axi_aw_t make_addr_beat(input logic [31:0] addr, input logic [7:0] len);
    axi_aw_t a;
    a       = '0;
    a.addr  = addr;
    a.id    = addr[9:2];   // Differs from one access to the next
    a.len   = len;
    a.size  = 3'd2;   // 4 bytes
    a.burst = 2'b01;
    return a;
endfunction

task automatic check_word(input string name, input word_t act, input word_t exp);
    if (act !== exp) begin
        $display("ERROR at %0t ns: %s = 0x%08h, expected 0x%08h", $time, name, act, exp);
        err_count++;
    end
endtask

task automatic check_resp(input string name, input axi_resp_e act, input axi_resp_e exp);
    if (act !== exp) begin
        $display("ERROR at %0t ns: %s = %b, expected %b", $time, name, act, exp);
        err_count++;
    end
endtask

task automatic check_cmderr(input cmderr_e exp);
    cmderr_e act;
    act = cmderr_e'(abstractcs[10:8]);
    if (act !== exp) begin
        $display("ERROR at %0t ns: cmderr = %0d, expected %0d", $time, act, exp);
        err_count++;
    end
endtask

task automatic check_bit(input string name, input logic act, input logic exp);
    if (act !== exp) begin
        $display("ERROR at %0t ns: %s = %b, expected %b", $time, name, act, exp);
        err_count++;
    end
endtask

task automatic report_test(input string name, input int errs_at_start);
    if (err_count == errs_at_start) begin
        $display("[%0t ns] %s: ok", $time, name);
    end else begin
        $display("[%0t ns] %s: %0d error(s)", $time, name, err_count - errs_at_start);
        tests_failed++;
    end
endtask

task automatic dmi_write(input logic [dmi_abits-1:0] addr, input word_t data);
    @(negedge dm_clk);
    dmi.wen  = 1'b1;
    dmi.ren  = 1'b0;
    dmi.addr = addr;
    dmi.data = data;
    @(negedge dm_clk);   // Taken on the edge in between
    dmi.wen = 1'b0;
endtask

task automatic dmi_select(input logic [dmi_abits-1:0] addr);
    @(negedge dm_clk);
    dmi.wen  = 1'b0;
    dmi.ren  = 1'b1;
    dmi.addr = addr;
    #1;
endtask

task automatic axi_write(input logic [31:0] addr, input word_t data, input logic [3:0] strb,
                         output axi_resp_e resp);
    @(negedge dm_clk);
    aw       = make_addr_beat(addr, 8'd0);
    aw_valid = 1'b1;
    #1;
    while (!aw_ready) begin
        @(negedge dm_clk);
        #1;
    end
    @(negedge dm_clk);
    aw_valid = 1'b0;
    w        = '{data: data, strb: strb, last: 1'b1};
    w_valid  = 1'b1;
    #1;
    while (!w_ready) begin
        @(negedge dm_clk);
        #1;
    end
    @(negedge dm_clk);
    w_valid = 1'b0;
    b_ready = 1'b1;
    #1;
    while (!b_valid) begin
        @(negedge dm_clk);
        #1;
    end
    resp = b.resp;
    check_word("b.id", word_t'(b.id), word_t'(aw.id));
    @(negedge dm_clk);
    b_ready = 1'b0;
endtask

task automatic axi_read(input logic [31:0] addr, input logic [7:0] len,
                        output word_t data, output axi_resp_e resp);
    @(negedge dm_clk);
    ar       = make_addr_beat(addr, len);
    ar_valid = 1'b1;
    #1;
    while (!ar_ready) begin
        @(negedge dm_clk);
        #1;
    end
    @(negedge dm_clk);
    ar_valid = 1'b0;
    r_ready  = 1'b1;
    #1;
    while (!r_valid) begin
        @(negedge dm_clk);
        #1;
    end
    data = r.data;
    resp = r.resp;
    check_word("r.id", word_t'(r.id), word_t'(ar.id));
    @(negedge dm_clk);
    r_ready = 1'b0;
endtask

task automatic core_event(input logic [31:0] addr);
    axi_resp_e resp;
    axi_write(addr, 32'h0, 4'hf, resp);
    check_resp("b.resp", resp, resp_okay);
endtask

task automatic read_flags(input word_t exp);
    word_t     rdata;
    axi_resp_e resp;
    axi_read(mem_flag, 8'd0, rdata, resp);
    check_resp("r.resp", resp, resp_okay);
    check_word("flag word", rdata, exp);
endtask

function automatic abs_cmd_t access_cmd(input logic [2:0] size, input logic postinc,
                                        input logic [15:0] regno);
    abs_cmd_t c;
    c               = '0;
    c.aarsize       = size;
    c.postincrement = postinc;
    c.transfer      = 1'b1;
    c.regno         = regno;
    return c;
endfunction

task automatic test_stored_words();
    int        errs;
    word_t     rdata;
    axi_resp_e resp;
    errs = err_count;
    for (int i = 0; i < data_count; i++) begin
        data_exp[i] = $random(seed);
        dmi_write(dmi_data0 + 7'(i), data_exp[i]);
    end
    for (int i = 0; i < progbuf_count; i++) begin
        prog_exp[i] = $random(seed);
        dmi_write(dmi_progbuf0 + 7'(i), prog_exp[i]);
    end
    for (int i = 0; i < data_count; i++) begin
        dmi_select(dmi_data0 + 7'(i));
        check_word("data_rd", data_rd, data_exp[i]);
        axi_read(mem_data_base + 32'(4 * i), 8'd0, rdata, resp);
        check_resp("r.resp", resp, resp_okay);
        check_word("r.data", rdata, data_exp[i]);
    end
    for (int i = 0; i < progbuf_count; i++) begin
        dmi_select(dmi_progbuf0 + 7'(i));
        check_word("progbuf_rd", progbuf_rd, prog_exp[i]);
        axi_read(mem_progbuf_base + 32'(4 * i), 8'd0, rdata, resp);
        check_resp("r.resp", resp, resp_okay);
        check_word("r.data", rdata, prog_exp[i]);
    end
    axi_read(32'h0000_0200, 8'd0, rdata, resp);   // Hole in the window
    check_resp("r.resp", resp, resp_slverr);
    axi_read(mem_data_base, 8'd1, rdata, resp);   // Burst request
    check_resp("r.resp", resp, resp_slverr);
    report_test("stored_words", errs);
endtask

task automatic test_strobe_merge();
    int        errs;
    word_t     new_w;
    word_t     exp;
    axi_resp_e resp;
    errs  = err_count;
    new_w = $random(seed);
    exp   = {data_exp[3][31:24], new_w[23:16], data_exp[3][15:8], new_w[7:0]};
    axi_write(mem_data_base + 32'd12, new_w, 4'b0101, resp);
    check_resp("b.resp", resp, resp_okay);
    data_exp[3] = exp;
    dmi_select(dmi_data0 + 7'd3);
    check_word("data_rd", data_rd, exp);
    report_test("strobe_merge", errs);
endtask

task automatic test_command_round_trip();
    int       errs;
    abs_cmd_t cmd;
    abs_cmd_t exp_cmd;
    errs = err_count;
    core_event(mem_halt);
    check_bit("halted", halted, 1'b1);
    cmd = access_cmd(3'd2, 1'b1, 16'h1000);
    dmi_write(dmi_command, word_t'(cmd));
    check_bit("busy", busy, 1'b1);
    check_word("abstractcs", abstractcs, 32'h1000_100c);   // 16 progbuf and 12 data words
    read_flags(32'h1);
    core_event(mem_going);
    read_flags(32'h0);
    core_event(mem_halt);
    check_bit("busy", busy, 1'b0);
    check_word("abstractcs", abstractcs, 32'h1000_000c);
    exp_cmd       = cmd;
    exp_cmd.regno = cmd.regno + 16'd1;
    check_word("command", command, word_t'(exp_cmd));
    report_test("command_round_trip", errs);
endtask

task automatic test_error_codes();
    int errs;
    errs = err_count;
    core_event(mem_resuming);   // Hart leaves halt
    dmi_write(dmi_command, word_t'(access_cmd(3'd2, 1'b0, 16'h1000)));
    check_cmderr(cmderr_haltresume);
    dmi_write(dmi_abstractcs, 32'h0000_0700);
    check_cmderr(cmderr_none);
    core_event(mem_halt);
    dmi_write(dmi_command, word_t'(access_cmd(3'd3, 1'b0, 16'h1000)));
    check_cmderr(cmderr_notsup);
    check_bit("busy", busy, 1'b0);
    dmi_write(dmi_abstractcs, 32'h0000_0700);
    check_cmderr(cmderr_none);
    dmi_write(dmi_command, word_t'(access_cmd(3'd2, 1'b0, 16'h1001)));
    check_bit("busy", busy, 1'b1);
    dmi_write(dmi_data0 + 7'd5, $random(seed));
    check_cmderr(cmderr_busy);
    dmi_select(dmi_data0 + 7'd5);
    check_word("data_rd", data_rd, data_exp[5]);
    dmi_write(dmi_abstractcs, 32'h0000_0700);
    check_cmderr(cmderr_none);
    core_event(mem_going);
    core_event(mem_halt);
    check_bit("busy", busy, 1'b0);
    core_event(mem_exception);
    check_cmderr(cmderr_exception);
    dmi_write(dmi_abstractcs, 32'h0000_0700);
    check_cmderr(cmderr_none);
    report_test("error_codes", errs);
endtask

task automatic test_resume();
    int errs;
    errs = err_count;
    dmi_write(dmi_dmcontrol, 32'h4000_0001);   // resumereq with dmactive
    check_bit("resumeack", resumeack, 1'b0);
    read_flags(32'h2);
    core_event(mem_resuming);
    check_bit("halted", halted, 1'b0);
    check_bit("resumeack", resumeack, 1'b1);
    read_flags(32'h0);
    report_test("resume", errs);
endtask

task automatic test_deactivation();
    int errs;
    errs = err_count;
    core_event(mem_halt);
    dmi_write(dmi_command, word_t'(access_cmd(3'd2, 1'b0, 16'h0300)));
    dmi_write(dmi_data0, 32'hdead_beef);   // Leaves a BUSY error behind
    check_cmderr(cmderr_busy);
    @(negedge dm_clk);
    dmactive = 1'b0;
    @(negedge dm_clk);
    dmactive = 1'b1;
    for (int i = 0; i < data_count; i++) begin
        dmi_select(dmi_data0 + 7'(i));
        check_word("data_rd", data_rd, 32'h0);
    end
    for (int i = 0; i < progbuf_count; i++) begin
        dmi_select(dmi_progbuf0 + 7'(i));
        check_word("progbuf_rd", progbuf_rd, 32'h0);
    end
    check_word("command", command, 32'h0);
    check_bit("busy", busy, 1'b0);
    check_cmderr(cmderr_none);
    report_test("deactivation", errs);
endtask

`endif

// ==== dv/dm_abstract_tb.sv ====
`timescale 1ns/1ps
module dm_abstract_tb;
    import dm_pkg::*;

    localparam int clk_period      = 4;
    localparam int reset_cycles    = 16;
    localparam int test_count      = 6;
    localparam int cycles_per_test = 400;

    logic      dm_clk;
    logic      dm_rst_n;
    logic      dmactive;
    dmi_req_t  dmi;
    logic      aw_valid;
    axi_aw_t   aw;
    logic      aw_ready;
    logic      w_valid;
    axi_w_t    w;
    logic      w_ready;
    logic      b_valid;
    axi_b_t    b;
    logic      b_ready;
    logic      ar_valid;
    axi_ar_t   ar;
    logic      ar_ready;
    logic      r_valid;
    axi_r_t    r;
    logic      r_ready;
    logic      halted;
    logic      resumeack;
    logic      busy;
    word_t     abstractcs;
    word_t     command;
    word_t     data_rd;
    word_t     progbuf_rd;

    int        err_count;
    int        tests_failed;
    int        seed;
    word_t     data_exp [data_count];
    word_t     prog_exp [progbuf_count];

    dm_abstract_top i_dm_abstract_top (
        .dm_clk     (dm_clk),
        .dm_rst_n   (dm_rst_n),
        .dmactive   (dmactive),
        .dmi        (dmi),
        .aw_valid   (aw_valid),
        .aw         (aw),
        .aw_ready   (aw_ready),
        .w_valid    (w_valid),
        .w          (w),
        .w_ready    (w_ready),
        .b_valid    (b_valid),
        .b          (b),
        .b_ready    (b_ready),
        .ar_valid   (ar_valid),
        .ar         (ar),
        .ar_ready   (ar_ready),
        .r_valid    (r_valid),
        .r          (r),
        .r_ready    (r_ready),
        .halted     (halted),
        .resumeack  (resumeack),
        .busy       (busy),
        .abstractcs (abstractcs),
        .command    (command),
        .data_rd    (data_rd),
        .progbuf_rd (progbuf_rd)
    );

    `include "dm_tb_tasks.svh"

    initial begin
        dm_clk = 1'b0;
        forever #(clk_period / 2) dm_clk = ~dm_clk;
    end

    initial begin
        #((test_count * cycles_per_test + reset_cycles) * clk_period);
        $display("Watchdog expired at %0t ns, a test is stuck waiting on the DUT", $time);
        $display("*** TEST FAILED ***");
        $finish;
    end

    initial begin
        err_count    = 0;
        tests_failed = 0;
        seed         = 4397;
        dm_rst_n     = 1'b0;
        dmactive     = 1'b1;
        dmi          = '0;
        aw_valid     = 1'b0;
        aw           = '0;
        w_valid      = 1'b0;
        w            = '0;
        b_ready      = 1'b0;
        ar_valid     = 1'b0;
        ar           = '0;
        r_ready      = 1'b0;
        repeat (reset_cycles) @(negedge dm_clk);
        dm_rst_n = 1'b1;

        test_stored_words();
        test_strobe_merge();
        test_command_round_trip();
        test_error_codes();
        test_resume();
        test_deactivation();

        err_count += i_dm_abstract_top.i_axi_slave.i_abstract_sva.fail_count;
        $display("Tests run: %0d, tests failed: %0d, errors: %0d",
                 test_count, tests_failed, err_count);
        if (err_count == 0) begin
            $display("*** TEST PASSED ***");
        end else begin
            $display("*** TEST FAILED ***");
        end
        $finish;
    end

endmodule

// ==== list.f ====
+incdir+include
source/dm_pkg.sv
source/dm_axi_slave.sv
source/dm_buffer_bank.sv
source/dm_cmd_ctrl.sv
source/dm_abstract_top.sv
dv/dm_abstract_sva.sv
dv/dm_abstract_tb.sv

// ==== source/dm_abstract_top.sv ====
`timescale 1ns/1ps
module dm_abstract_top (
    input  logic             dm_clk,
    input  logic             dm_rst_n,
    input  logic             dmactive,
    input  dm_pkg::dmi_req_t dmi,
    input  logic             aw_valid,
    input  dm_pkg::axi_aw_t  aw,
    output logic             aw_ready,
    input  logic             w_valid,
    input  dm_pkg::axi_w_t   w,
    output logic             w_ready,
    output logic             b_valid,
    output dm_pkg::axi_b_t   b,
    input  logic             b_ready,
    input  logic             ar_valid,
    input  dm_pkg::axi_ar_t  ar,
    output logic             ar_ready,
    output logic             r_valid,
    output dm_pkg::axi_r_t   r,
    input  logic             r_ready,
    output logic             halted,
    output logic             resumeack,
    output logic             busy,
    output dm_pkg::word_t    abstractcs,
    output dm_pkg::word_t    command,
    output dm_pkg::word_t    data_rd,
    output dm_pkg::word_t    progbuf_rd
);
    import dm_pkg::*;

    mem_wr_t    mem_wr;
    core_evt_t  evt;
    buf_sel_e   rd_region;
    logic [3:0] rd_index;
    word_t      rd_word;
    logic [1:0] flags;
    logic       buf_lock;

    dm_axi_slave i_axi_slave (
        .dm_clk    (dm_clk),
        .dm_rst_n  (dm_rst_n),
        .aw_valid  (aw_valid),
        .aw        (aw),
        .aw_ready  (aw_ready),
        .w_valid   (w_valid),
        .w         (w),
        .w_ready   (w_ready),
        .b_valid   (b_valid),
        .b         (b),
        .b_ready   (b_ready),
        .ar_valid  (ar_valid),
        .ar        (ar),
        .ar_ready  (ar_ready),
        .r_valid   (r_valid),
        .r         (r),
        .r_ready   (r_ready),
        .mem_wr    (mem_wr),
        .evt       (evt),
        .rd_region (rd_region),
        .rd_index  (rd_index),
        .rd_word   (rd_word),
        .flags     (flags)
    );

    dm_buffer_bank i_buffer_bank (
        .dm_clk     (dm_clk),
        .dm_rst_n   (dm_rst_n),
        .dmactive   (dmactive),
        .dmi        (dmi),
        .buf_lock   (buf_lock),
        .mem_wr     (mem_wr),
        .rd_region  (rd_region),
        .rd_index   (rd_index),
        .rd_word    (rd_word),
        .data_rd    (data_rd),
        .progbuf_rd (progbuf_rd)
    );

    dm_cmd_ctrl i_cmd_ctrl (
        .dm_clk     (dm_clk),
        .dm_rst_n   (dm_rst_n),
        .dmactive   (dmactive),
        .dmi        (dmi),
        .evt        (evt),
        .flags      (flags),
        .buf_lock   (buf_lock),
        .halted     (halted),
        .resumeack  (resumeack),
        .busy       (busy),
        .abstractcs (abstractcs),
        .command    (command)
    );

endmodule

// ==== source/dm_axi_slave.sv ====
`timescale 1ns/1ps
module dm_axi_slave (
    input  logic              dm_clk,
    input  logic              dm_rst_n,
    input  logic              aw_valid,
    input  dm_pkg::axi_aw_t   aw,
    output logic              aw_ready,
    input  logic              w_valid,
    input  dm_pkg::axi_w_t    w,
    output logic              w_ready,
    output logic              b_valid,
    output dm_pkg::axi_b_t    b,
    input  logic              b_ready,
    input  logic              ar_valid,
    input  dm_pkg::axi_ar_t   ar,
    output logic              ar_ready,
    output logic              r_valid,
    output dm_pkg::axi_r_t    r,
    input  logic              r_ready,
    output dm_pkg::mem_wr_t   mem_wr,
    output dm_pkg::core_evt_t evt,
    output dm_pkg::buf_sel_e  rd_region,
    output logic [3:0]        rd_index,
    input  dm_pkg::word_t     rd_word,
    input  logic [1:0]        flags
);
    import dm_pkg::*;

    typedef enum logic [1:0] {
        st_idle,
        st_read,
        st_write,
        st_wback
    } state_e;

    state_e              state;
    logic [axi_id_w-1:0] id_q;
    axi_resp_e           resp_q;
    word_t               rdata_q;
    buf_sel_e            wr_region;
    logic [3:0]          wr_index;
    core_evt_t           wr_evt;
    logic                aw_fire;
    logic                w_fire;
    logic                ar_fire;
    buf_sel_e            aw_region;
    core_evt_t           aw_evt;
    logic                aw_ok;
    logic                ar_ok;
    logic                ar_flag;

    // Only single-beat, plain accesses are served
    function automatic logic attr_err(axi_aw_t a);
        return (|a.len) | a.lock | (|a.cache) | (|a.prot) | (|a.qos) | (|a.region);
    endfunction

    function automatic buf_sel_e region_of(logic [axi_addr_w-1:0] addr);
        buf_sel_e sel;
        sel = sel_none;
        if (addr[1:0] == 2'b00) begin
            if (addr >= mem_data_base && addr < mem_data_base + 4 * data_count) begin
                sel = sel_data;
            end else if (addr >= mem_progbuf_base &&
                         addr < mem_progbuf_base + 4 * progbuf_count) begin
                sel = sel_progbuf;
            end
        end
        return sel;
    endfunction

    function automatic core_evt_t evt_of(logic [axi_addr_w-1:0] addr);
        core_evt_t e;
        e.halt      = (addr == mem_halt);
        e.going     = (addr == mem_going);
        e.resuming  = (addr == mem_resuming);
        e.exception = (addr == mem_exception);
        return e;
    endfunction

    assign aw_fire   = aw_valid & aw_ready;
    assign w_fire    = w_valid & w_ready;
    assign ar_fire   = ar_valid & ar_ready;
    assign aw_region = region_of(aw.addr);
    assign aw_evt    = evt_of(aw.addr);
    assign aw_ok     = !attr_err(aw) && (aw_region != sel_none || aw_evt != core_evt_t'('0));
    assign rd_region = region_of(ar.addr); // Bank lookup from the live AR address
    assign rd_index  = ar.addr[5:2];
    assign ar_flag   = (ar.addr == mem_flag);
    assign ar_ok     = !attr_err(ar) && (rd_region != sel_none || ar_flag);

    always_ff @(posedge dm_clk or negedge dm_rst_n) begin
        if (!dm_rst_n) begin
            state <= st_idle;
        end else begin
            case (state)
                st_idle: begin
                    if (aw_fire) begin
                        state <= st_write; // Writes win over reads
                    end else if (ar_fire) begin
                        state <= st_read;
                    end
                end
                st_write: begin
                    if (w_fire && w.last) begin
                        state <= st_wback;
                    end
                end
                st_wback: begin
                    if (b_valid && b_ready) begin
                        state <= st_idle;
                    end
                end
                st_read: begin
                    if (r_valid && r_ready) begin
                        state <= st_idle;
                    end
                end
                default: state <= st_idle;
            endcase
        end
    end

    always_ff @(posedge dm_clk) begin
        if (aw_fire) begin
            id_q      <= aw.id;
            resp_q    <= aw_ok ? resp_okay : resp_slverr;
            wr_region <= aw_ok ? aw_region : sel_none; // Error writes only drain W
            wr_index  <= aw.addr[5:2];
            wr_evt    <= aw_ok ? aw_evt : core_evt_t'('0);
        end else if (ar_fire) begin
            id_q    <= ar.id;
            resp_q  <= ar_ok ? resp_okay : resp_slverr;
            rdata_q <= !ar_ok ? '0 : (ar_flag ? {30'b0, flags} : rd_word);
        end
    end

    assign aw_ready = (state == st_idle);
    assign ar_ready = (state == st_idle) && !aw_valid;
    assign w_ready  = (state == st_write);
    assign b_valid  = (state == st_wback);
    assign r_valid  = (state == st_read);

    assign b = '{id: id_q, resp: resp_q};
    assign r = '{id: id_q, resp: resp_q, data: rdata_q, last: 1'b1};

    assign mem_wr = '{en:     w_fire && (wr_region != sel_none),
                      region: wr_region,
                      index:  wr_index,
                      data:   w.data,
                      strb:   w.strb};
    assign evt = w_fire ? wr_evt : core_evt_t'('0); // One pulse per beat

endmodule

// ==== source/dm_buffer_bank.sv ====
`timescale 1ns/1ps
module dm_buffer_bank (
    input  logic             dm_clk,
    input  logic             dm_rst_n,
    input  logic             dmactive,
    input  dm_pkg::dmi_req_t dmi,
    input  logic             buf_lock,
    input  dm_pkg::mem_wr_t  mem_wr,
    input  dm_pkg::buf_sel_e rd_region,
    input  logic [3:0]       rd_index,
    output dm_pkg::word_t    rd_word,
    output dm_pkg::word_t    data_rd,
    output dm_pkg::word_t    progbuf_rd
);
    import dm_pkg::*;

    word_t      data_q    [data_count];
    word_t      progbuf_q [progbuf_count];
    logic       data_hit;
    logic       progbuf_hit;
    logic [3:0] data_idx;
    logic       dbg_data_wen;
    logic       dbg_progbuf_wen;
    logic       core_data_wen;
    logic       core_progbuf_wen;

    function automatic word_t merge(word_t old_w, word_t new_w, logic [3:0] strb);
        word_t res;
        for (int i = 0; i < 4; i++) begin
            res[8*i +: 8] = strb[i] ? new_w[8*i +: 8] : old_w[8*i +: 8];
        end
        return res;
    endfunction

    assign data_hit    = (dmi.addr >= dmi_data0) && (dmi.addr < dmi_data0 + data_count);
    assign progbuf_hit = (dmi.addr >= dmi_progbuf0) && (dmi.addr < dmi_progbuf0 + progbuf_count);
    assign data_idx    = 4'(dmi.addr - dmi_data0);

    assign dbg_data_wen     = dmi.wen && data_hit && !buf_lock;
    assign dbg_progbuf_wen  = dmi.wen && progbuf_hit && !buf_lock;
    assign core_data_wen    = mem_wr.en && (mem_wr.region == sel_data);
    assign core_progbuf_wen = mem_wr.en && (mem_wr.region == sel_progbuf);

    always_ff @(posedge dm_clk or negedge dm_rst_n) begin
        if (!dm_rst_n) begin
            data_q    <= '{default: '0};
            progbuf_q <= '{default: '0};
        end else if (!dmactive) begin
            data_q    <= '{default: '0};
            progbuf_q <= '{default: '0};
        end else begin
            // Debugger write beats a core write to the same word
            for (int i = 0; i < data_count; i++) begin
                if (dbg_data_wen && data_idx == i) begin
                    data_q[i] <= dmi.data;
                end else if (core_data_wen && mem_wr.index == i) begin
                    data_q[i] <= merge(data_q[i], mem_wr.data, mem_wr.strb);
                end
            end
            for (int i = 0; i < progbuf_count; i++) begin
                if (dbg_progbuf_wen && dmi.addr[3:0] == i) begin
                    progbuf_q[i] <= dmi.data;
                end else if (core_progbuf_wen && mem_wr.index == i) begin
                    progbuf_q[i] <= merge(progbuf_q[i], mem_wr.data, mem_wr.strb);
                end
            end
        end
    end

    always_comb begin
        rd_word = '0;
        case (rd_region)
            sel_data: begin
                if (rd_index < data_count) begin
                    rd_word = data_q[rd_index];
                end
            end
            sel_progbuf: rd_word = progbuf_q[rd_index];
            default:     rd_word = '0;
        endcase
    end

    assign data_rd    = data_hit ? data_q[data_idx] : '0;
    assign progbuf_rd = progbuf_q[dmi.addr[3:0]];

endmodule

// ==== source/dm_cmd_ctrl.sv ====
`timescale 1ns/1ps
module dm_cmd_ctrl (
    input  logic              dm_clk,
    input  logic              dm_rst_n,
    input  logic              dmactive,
    input  dm_pkg::dmi_req_t  dmi,
    input  dm_pkg::core_evt_t evt,
    output logic [1:0]        flags,
    output logic              buf_lock,
    output logic              halted,
    output logic              resumeack,
    output logic              busy,
    output dm_pkg::word_t     abstractcs,
    output dm_pkg::word_t     command
);
    import dm_pkg::*;

    abs_cmd_t cmd_q;
    abs_cmd_t cmd_wr;
    cmderr_e  cmderr_q;
    logic     going_q;
    logic     resume_q;
    logic     cmd_wr_en;
    logic     cs_wr_en;
    logic     resume_req;
    logic     buf_wr_en;
    logic     cmd_legal;
    logic     cmd_start;
    logic     cmd_done;

    assign cmd_wr     = abs_cmd_t'(dmi.data);
    assign cmd_wr_en  = dmi.wen && (dmi.addr == dmi_command);
    assign cs_wr_en   = dmi.wen && (dmi.addr == dmi_abstractcs);
    assign resume_req = dmi.wen && (dmi.addr == dmi_dmcontrol) && dmi.data[30] && dmi.data[0];
    assign buf_wr_en  = dmi.wen &&
                        ((dmi.addr >= dmi_data0 && dmi.addr < dmi_data0 + data_count) ||
                         (dmi.addr >= dmi_progbuf0 && dmi.addr < dmi_progbuf0 + progbuf_count));

    // Access register of 32 bits in the GPR/CSR range
    assign cmd_legal = (cmd_wr.cmdtype == 8'h00) && (cmd_wr.aarsize == 3'd2) &&
                       (cmd_wr.regno < regno_limit);
    assign cmd_start = cmd_wr_en && !busy && (cmderr_q == cmderr_none) && halted && cmd_legal;
    assign cmd_done  = busy && evt.halt && !going_q; // Core parked again after running

    always_ff @(posedge dm_clk or negedge dm_rst_n) begin
        if (!dm_rst_n) begin
            busy     <= 1'b0;
            cmd_q    <= '0;
            cmderr_q <= cmderr_none;
        end else if (!dmactive) begin
            busy     <= 1'b0;
            cmd_q    <= '0;
            cmderr_q <= cmderr_none;
        end else begin
            if (cmd_start) begin
                busy <= 1'b1;
            end else if (cmd_done) begin
                busy <= 1'b0;
            end
            if (cmd_wr_en && !busy) begin
                cmd_q <= cmd_wr;
            end else if (cmd_done && cmd_q.postincrement) begin
                cmd_q.regno <= cmd_q.regno + 16'd1;
            end
            // First error sticks until cleared
            if (cmderr_q != cmderr_none) begin
                if (cs_wr_en) begin
                    cmderr_q <= cmderr_e'(cmderr_q & ~dmi.data[10:8]);
                end
            end else if (evt.exception) begin
                cmderr_q <= cmderr_exception;
            end else if (busy && (buf_wr_en || cmd_wr_en || cs_wr_en)) begin
                cmderr_q <= cmderr_busy;
            end else if (cmd_wr_en && !halted) begin
                cmderr_q <= cmderr_haltresume;
            end else if (cmd_wr_en && !cmd_legal) begin
                cmderr_q <= cmderr_notsup;
            end
        end
    end

    always_ff @(posedge dm_clk or negedge dm_rst_n) begin
        if (!dm_rst_n) begin
            going_q   <= 1'b0;
            resume_q  <= 1'b0;
            halted    <= 1'b0;
            resumeack <= 1'b0;
        end else begin
            if (evt.going) begin
                going_q <= 1'b0; // Core has picked up the command
            end else if (cmd_start) begin
                going_q <= 1'b1;
            end
            if (evt.resuming) begin
                resume_q  <= 1'b0;
                halted    <= 1'b0;
                resumeack <= 1'b1;
            end else begin
                if (resume_req) begin
                    resume_q  <= 1'b1;
                    resumeack <= 1'b0;
                end
                if (evt.halt) begin
                    halted <= 1'b1;
                end
            end
        end
    end

    assign flags      = {resume_q, going_q}; // Bit 0 going, bit 1 resume
    assign buf_lock   = busy;
    assign command    = cmd_q;
    assign abstractcs = {3'b0, 5'(progbuf_count), 11'b0, busy, 1'b0, cmderr_q,
                         4'b0, 4'(data_count)};

endmodule

// ==== source/dm_pkg.sv ====
package dm_pkg;

    localparam int axi_addr_w    = 32;
    localparam int axi_id_w      = 8;
    localparam int dmi_abits     = 7;
    localparam int data_count    = 12;
    localparam int progbuf_count = 16;

    // Debugger register map
    localparam logic [dmi_abits-1:0] dmi_data0      = 7'h04;
    localparam logic [dmi_abits-1:0] dmi_dmcontrol  = 7'h10;
    localparam logic [dmi_abits-1:0] dmi_abstractcs = 7'h16;
    localparam logic [dmi_abits-1:0] dmi_command    = 7'h17;
    localparam logic [dmi_abits-1:0] dmi_progbuf0   = 7'h20;

    // Core side debug memory window
    localparam logic [axi_addr_w-1:0] mem_halt         = 32'h0000_0100;
    localparam logic [axi_addr_w-1:0] mem_going        = 32'h0000_0104;
    localparam logic [axi_addr_w-1:0] mem_resuming     = 32'h0000_0108;
    localparam logic [axi_addr_w-1:0] mem_exception    = 32'h0000_010C;
    localparam logic [axi_addr_w-1:0] mem_flag         = 32'h0000_0400;
    localparam logic [axi_addr_w-1:0] mem_progbuf_base = 32'h0000_0340;
    localparam logic [axi_addr_w-1:0] mem_data_base    = 32'h0000_0380;

    localparam logic [15:0] regno_limit = 16'h1040;

    typedef logic [31:0] word_t;

    typedef struct packed {
        logic                 wen;
        logic                 ren;
        logic [dmi_abits-1:0] addr;
        word_t                data;
    } dmi_req_t;

    typedef struct packed {
        logic [axi_addr_w-1:0] addr;
        logic [axi_id_w-1:0]   id;
        logic [7:0]            len;
        logic [2:0]            size;
        logic [1:0]            burst;
        logic                  lock;
        logic [3:0]            cache;
        logic [2:0]            prot;
        logic [3:0]            qos;
        logic [3:0]            region;
    } axi_aw_t;

    typedef axi_aw_t axi_ar_t;

    typedef struct packed {
        word_t      data;
        logic [3:0] strb;
        logic       last;
    } axi_w_t;

    typedef enum logic [1:0] {
        resp_okay   = 2'b00,
        resp_slverr = 2'b10
    } axi_resp_e;

    typedef struct packed {
        logic [axi_id_w-1:0] id;
        axi_resp_e           resp;
    } axi_b_t;

    typedef struct packed {
        logic [axi_id_w-1:0] id;
        axi_resp_e           resp;
        word_t               data;
        logic                last;
    } axi_r_t;

    typedef enum logic [1:0] {
        sel_none    = 2'd0,
        sel_data    = 2'd1,
        sel_progbuf = 2'd2
    } buf_sel_e;

    typedef struct packed {
        logic       en;
        buf_sel_e   region;
        logic [3:0] index;
        word_t      data;
        logic [3:0] strb;
    } mem_wr_t;

    typedef struct packed {
        logic halt;
        logic going;
        logic resuming;
        logic exception;
    } core_evt_t;

    typedef enum logic [2:0] {
        cmderr_none       = 3'd0,
        cmderr_busy       = 3'd1,
        cmderr_notsup     = 3'd2,
        cmderr_exception  = 3'd3,
        cmderr_haltresume = 3'd4
    } cmderr_e;

    typedef struct packed {
        logic [7:0]  cmdtype;
        logic        reserved;
        logic [2:0]  aarsize;
        logic        postincrement;
        logic        postexec;
        logic        transfer;
        logic        write;
        logic [15:0] regno;
    } abs_cmd_t;

endpackage
